//--- common/motor_settings.svh
//////////////////////////////
// Widths and register map of the motor subsystem
// DRIVE_BAUD_DIV gives 115200 baud only with a clock near 13.4 MHz
//////////////////////////////
`ifndef MOTOR_SETTINGS_SVH
`define MOTOR_SETTINGS_SVH

// Register bus
`define REG_ADDR_W          6       // Address bits
`define REG_DATA_W          8       // Data bits

// Motors
`define NUM_MOTORS          4       // Drive motors, also servos
`define DRIVE_PWR_W         5       // Power field of a drive command
`define DRIVE_BAUD_DIV      116     // Clocks per UART bit

// Register map
`define ADDR_DRIVE_BASE     0       // Drive commands, one per motor
`define ADDR_SERVO_BASE     4       // Servo positions, one per servo
`define ADDR_LED_CTRL       8       // LED control and test mode
`define ADDR_FAULT_STAT     9       // Fault mask, read only

`endif

//--- common/motor_pkg.sv
//////////////////////////////
// Types shared by the register file, UARTs and servo PWMs
//////////////////////////////
`include "motor_settings.svh"

package motor_pkg;

    //////////////////////////////
    // Register bus
    //////////////////////////////
    typedef logic [`REG_ADDR_W-1:0]     reg_addr_t;     // Bus address
    typedef logic [`REG_DATA_W-1:0]     reg_data_t;     // Bus data

    //////////////////////////////
    // Motor payloads
    //////////////////////////////
    // Bit 7 brake, bit 6 enable, bit 5 direction, bits 4-0 power
    typedef logic [`DRIVE_PWR_W+2:0]    drive_cmd_t;
    typedef logic [7:0]                 servo_pos_t;    // High counts out of 256
    typedef logic [`NUM_MOTORS-1:0]     motor_mask_t;   // One bit per motor

    // UART frame position
    typedef enum logic [1:0] {
        START_BIT,                                      // Line low
        DATA_BITS,                                      // Byte, LSB first
        STOP_BIT                                        // Line high
    } uart_state_t;

endpackage

//--- rtl/motor_regs.sv
//////////////////////////////
// Bus writes land at the write edge, reads return one cycle later
// Unmapped addresses read 0, fault register ignores writes
//////////////////////////////
`include "motor_settings.svh"

module motor_regs (
    input  logic                    clock,
    input  logic                    reset_n,
    input  motor_pkg::reg_addr_t    address,        // Register address
    input  logic                    write_en,       // Write strobe
    input  logic                    read_en,        // Read strobe
    input  motor_pkg::reg_data_t    wr_data,        // Write data
    input  motor_pkg::motor_mask_t  sr_fault,       // Rotation motor faults
    output motor_pkg::reg_data_t    rd_data,        // Held until next read
    output motor_pkg::drive_cmd_t   drive_cmd0,     // To drive UART 0
    output motor_pkg::drive_cmd_t   drive_cmd1,
    output motor_pkg::drive_cmd_t   drive_cmd2,
    output motor_pkg::drive_cmd_t   drive_cmd3,
    output motor_pkg::servo_pos_t   servo_pos0,     // To servo PWM 0
    output motor_pkg::servo_pos_t   servo_pos1,
    output motor_pkg::servo_pos_t   servo_pos2,
    output motor_pkg::servo_pos_t   servo_pos3,
    output logic                    status_fault,   // Fault LED
    output logic                    status_pi,      // Orange Pi LED
    output logic                    status_ps4,     // PS4 controller LED
    output logic                    status_debug    // Debug LED
);
    import motor_pkg::*;

    drive_cmd_t drive_reg [`NUM_MOTORS];            // Drive command per motor
    servo_pos_t servo_reg [`NUM_MOTORS];            // Servo position per servo
    reg_data_t  led_ctrl;                           // LED control bits
    reg_data_t  rd_next;                            // Read mux result
    logic       test_en;                            // LED test mode

    //////////////////////////////
    // Register writes
    //////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `NUM_MOTORS; i++) begin
                drive_reg[i] <= '0;
                servo_reg[i] <= '0;
            end
            led_ctrl <= '0;
        end else if (write_en) begin
            for (int i = 0; i < `NUM_MOTORS; i++) begin
                if (address == reg_addr_t'(`ADDR_DRIVE_BASE + i))
                    drive_reg[i] <= wr_data;        // Sent from next frame on
                if (address == reg_addr_t'(`ADDR_SERVO_BASE + i))
                    servo_reg[i] <= wr_data;        // Latched at period wrap
            end
            if (address == reg_addr_t'(`ADDR_LED_CTRL))
                led_ctrl <= wr_data;
        end
    end

    //////////////////////////////
    // Read-back
    //////////////////////////////
    always_comb begin
        rd_next = '0;                               // Unmapped reads 0
        for (int i = 0; i < `NUM_MOTORS; i++) begin
            if (address == reg_addr_t'(`ADDR_DRIVE_BASE + i))
                rd_next = drive_reg[i];
            if (address == reg_addr_t'(`ADDR_SERVO_BASE + i))
                rd_next = servo_reg[i];
        end
        if (address == reg_addr_t'(`ADDR_LED_CTRL))
            rd_next = led_ctrl;
        if (address == reg_addr_t'(`ADDR_FAULT_STAT))
            rd_next = reg_data_t'(sr_fault);        // Live mask, bits 3-0
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n)
            rd_data <= '0;
        else if (read_en)
            rd_data <= rd_next;                     // One cycle latency
    end

    assign drive_cmd0 = drive_reg[0];
    assign drive_cmd1 = drive_reg[1];
    assign drive_cmd2 = drive_reg[2];
    assign drive_cmd3 = drive_reg[3];
    assign servo_pos0 = servo_reg[0];
    assign servo_pos1 = servo_reg[1];
    assign servo_pos2 = servo_reg[2];
    assign servo_pos3 = servo_reg[3];

    //////////////////////////////
    // Status LEDs
    //////////////////////////////
    assign test_en      = led_ctrl[0];
    assign status_fault = test_en ? led_ctrl[3] : |sr_fault;    // Any rotation fault
    assign status_pi    = test_en ? 1'b1        : led_ctrl[1];  // Forced on in test
    assign status_ps4   = test_en ? 1'b1        : led_ctrl[2];
    assign status_debug = test_en ? led_ctrl[4] : 1'b1;         // Hot-motor LED in test

endmodule

//--- drive_uart/drive_uart_tx.sv
//////////////////////////////
// Sends tx_data as back-to-back 8N1 frames, no idle between them
// tx_data is sampled once, as each start bit begins
//////////////////////////////
`include "motor_settings.svh"

module drive_uart_tx #(
    parameter int clks_per_bit = `DRIVE_BAUD_DIV    // Clocks per bit, sets baud
) (
    input  logic                    clock,
    input  logic                    reset_n,
    input  motor_pkg::drive_cmd_t   tx_data,        // Command byte to repeat
    output logic                    uart_tx         // Serial line to motor
);
    import motor_pkg::*;

    localparam int cnt_w     = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam int data_bits = $bits(drive_cmd_t);
    localparam int idx_w     = $clog2(data_bits);

    uart_state_t        state;                      // Frame position
    logic [cnt_w-1:0]   baud_cnt;                   // Clocks within a bit
    logic [idx_w-1:0]   bit_idx;                    // Data bit in flight
    drive_cmd_t         shift_reg;                  // Byte being sent
    logic               bit_end;                    // Last clock of a bit

    assign bit_end = (baud_cnt == cnt_w'(clks_per_bit - 1));

    //////////////////////////////
    // Frame FSM
    //////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state    <= START_BIT;                  // Frame starts right out of reset
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            if (bit_end)
                baud_cnt <= '0;
            else
                baud_cnt <= baud_cnt + 1'b1;
            case (state)
                START_BIT: if (bit_end) begin
                    state   <= DATA_BITS;
                    bit_idx <= '0;
                end
                DATA_BITS: if (bit_end) begin
                    if (bit_idx == idx_w'(data_bits - 1))
                        state <= STOP_BIT;          // Byte done
                    else
                        bit_idx <= bit_idx + 1'b1;
                end
                STOP_BIT: if (bit_end)
                    state <= START_BIT;             // Next frame, no gap
                default: state <= START_BIT;
            endcase
        end
    end

    // Payload shifter
    always_ff @(posedge clock) begin
        if (state == START_BIT && baud_cnt == '0)
            shift_reg <= tx_data;                   // Fresh command per frame
        else if (state == DATA_BITS && bit_end)
            shift_reg <= shift_reg >> 1;            // LSB first
    end

    always_comb begin
        case (state)
            START_BIT: uart_tx = 1'b0;
            DATA_BITS: uart_tx = shift_reg[0];
            default:   uart_tx = 1'b1;              // Stop bit
        endcase
    end

endmodule

//--- rtl/servo_pwm.sv
//////////////////////////////
// 256-clock period, position latched only at the period wrap
//////////////////////////////
module servo_pwm (
    input  logic                    clock,
    input  logic                    reset_n,
    input  motor_pkg::servo_pos_t   position,       // High counts per period
    output logic                    pwm_signal      // Registered PWM wave
);
    import motor_pkg::*;

    servo_pos_t period_cnt;                         // Free-running, wraps to 0
    servo_pos_t pos_shadow;                         // Position for this period
    logic       wrap;                               // Last clock of period

    assign wrap = (period_cnt == '1);

    //////////////////////////////
    // Counter, shadow and compare
    //////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            period_cnt <= '0;
            pos_shadow <= '0;                       // Output low until first latch
            pwm_signal <= 1'b0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
            if (wrap)
                pos_shadow <= position;             // Glitch-free ratio change
            // Count 255 never beats any shadow, so a new period starts low
            pwm_signal <= (period_cnt < pos_shadow);
        end
    end

endmodule

//--- rtl/motor_subsystem.sv
//////////////////////////////
// Motor command core driven by the parallel register bus
// reset_n comes from outside, all logic on one clock
//////////////////////////////
`include "motor_settings.svh"

module motor_subsystem (
    input  logic                    clock,
    input  logic                    reset_n,
    input  motor_pkg::reg_addr_t    address,        // Register bus
    input  logic                    write_en,
    input  motor_pkg::reg_data_t    wr_data,
    input  logic                    read_en,
    input  motor_pkg::motor_mask_t  sr_fault,       // Rotation motor faults
    output motor_pkg::reg_data_t    rd_data,
    output motor_pkg::motor_mask_t  sd_uart,        // Drive motor UART lines
    output motor_pkg::motor_mask_t  servo_pwm,      // Arm servo PWM waves
    output logic                    status_fault,
    output logic                    status_pi,
    output logic                    status_ps4,
    output logic                    status_debug
);
    import motor_pkg::*;

    drive_cmd_t drive_cmd [`NUM_MOTORS];            // Register file to UARTs
    servo_pos_t servo_pos [`NUM_MOTORS];            // Register file to PWMs

    //////////////////////////////
    // Register file
    //////////////////////////////
    motor_regs u_motor_regs (
        .clock          (clock),
        .reset_n        (reset_n),
        .address        (address),
        .write_en       (write_en),
        .read_en        (read_en),
        .wr_data        (wr_data),
        .sr_fault       (sr_fault),
        .rd_data        (rd_data),
        .drive_cmd0     (drive_cmd[0]),
        .drive_cmd1     (drive_cmd[1]),
        .drive_cmd2     (drive_cmd[2]),
        .drive_cmd3     (drive_cmd[3]),
        .servo_pos0     (servo_pos[0]),
        .servo_pos1     (servo_pos[1]),
        .servo_pos2     (servo_pos[2]),
        .servo_pos3     (servo_pos[3]),
        .status_fault   (status_fault),
        .status_pi      (status_pi),
        .status_ps4     (status_ps4),
        .status_debug   (status_debug)
    );

    //////////////////////////////
    // Per-motor UART and servo PWM
    //////////////////////////////
    for (genvar i = 0; i < `NUM_MOTORS; i++) begin : g_motor
        drive_uart_tx #(
            .clks_per_bit   (`DRIVE_BAUD_DIV)       // 115200 baud
        ) u_drive_uart (
            .clock          (clock),
            .reset_n        (reset_n),
            .tx_data        (drive_cmd[i]),
            .uart_tx        (sd_uart[i])
        );

        servo_pwm u_servo_pwm (
            .clock          (clock),
            .reset_n        (reset_n),
            .position       (servo_pos[i]),
            .pwm_signal     (servo_pwm[i])
        );
    end

endmodule

//--- verification/motor_subsystem_checker.sv
//////////////////////////////
// Sampled on every rising clock edge, idle while reset_n is low
// Shadow and test-enable inputs reach inside the DUT through the bind
//////////////////////////////
module motor_subsystem_checker (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    write_en,
    input  logic                    read_en,
    input  logic                    test_en,        // LED control bit 0
    input  logic                    status_pi,
    input  logic                    status_ps4,
    input  motor_pkg::motor_mask_t  servo_pwm,
    input  motor_pkg::servo_pos_t   shadow0,        // Latched servo positions
    input  motor_pkg::servo_pos_t   shadow1,
    input  motor_pkg::servo_pos_t   shadow2,
    input  motor_pkg::servo_pos_t   shadow3
);
    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////
    // Bus and LED rules
    //////////////////////////////
    bus_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
        !(write_en && read_en)) else $error("write_en and read_en high together");

    led_test_forced: assert property (@(posedge clock) disable iff (!reset_n)
        test_en |-> (status_pi && status_ps4)) else $error("Pi or PS4 LED off in test mode");

    // Zero position keeps the servo line low
    pwm0_idle: assert property (@(posedge clock) disable iff (!reset_n)
        (shadow0 == '0) |-> !servo_pwm[0]) else $error("Servo 0 high with position 0");
    pwm1_idle: assert property (@(posedge clock) disable iff (!reset_n)
        (shadow1 == '0) |-> !servo_pwm[1]) else $error("Servo 1 high with position 0");
    pwm2_idle: assert property (@(posedge clock) disable iff (!reset_n)
        (shadow2 == '0) |-> !servo_pwm[2]) else $error("Servo 2 high with position 0");
    pwm3_idle: assert property (@(posedge clock) disable iff (!reset_n)
        (shadow3 == '0) |-> !servo_pwm[3]) else $error("Servo 3 high with position 0");

endmodule

bind motor_subsystem motor_subsystem_checker u_checker (
    .clock      (clock),
    .reset_n    (reset_n),
    .write_en   (write_en),
    .read_en    (read_en),
    .test_en    (u_motor_regs.led_ctrl[0]),
    .status_pi  (status_pi),
    .status_ps4 (status_ps4),
    .servo_pwm  (servo_pwm),
    .shadow0    (g_motor[0].u_servo_pwm.pos_shadow),
    .shadow1    (g_motor[1].u_servo_pwm.pos_shadow),
    .shadow2    (g_motor[2].u_servo_pwm.pos_shadow),
    .shadow3    (g_motor[3].u_servo_pwm.pos_shadow)
);

//--- verification/motor_subsystem_tb.sv
//////////////////////////////
// Opens verification/motor_input.txt relative to the project root
// Monitors lock to the frame and PWM period counted from reset release
//////////////////////////////
`include "motor_settings.svh"

module motor_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import motor_pkg::*;

    localparam int frame_clks = 10 * `DRIVE_BAUD_DIV;   // Start, 8 data, stop
    localparam int pwm_period = 256;

    logic           clock;
    logic           reset_n;
    reg_addr_t      address;
    logic           write_en;
    reg_data_t      wr_data;
    logic           read_en;
    motor_mask_t    sr_fault;
    reg_data_t      rd_data;
    motor_mask_t    sd_uart;
    motor_mask_t    servo_pwm;
    logic           status_fault;
    logic           status_pi;
    logic           status_ps4;
    logic           status_debug;

    string          cmd_lines [$];                      // Command lines without comments
    int             file_lines  = 0;
    int             cycle_limit = 0;
    int             cycle_cnt   = 0;
    int             since_reset = 0;                    // Rising edges since reset release
    int             pass_cnt    = 0;
    int             fail_cnt    = 0;
    logic [31:0]    lfsr        = 32'h92a97eea;
    bit             loaded;

    motor_subsystem i_motor_subsystem (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;                     // 100 ns period
    end

    always @(posedge clock) begin
        cycle_cnt   <= cycle_cnt + 1;
        since_reset <= reset_n ? since_reset + 1 : 0;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: run still busy after %0d clock cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_fault();
        for (int i = 0; i < `NUM_MOTORS; i++) begin
            lfsr        = lfsr_step(lfsr);
            sr_fault[i] = lfsr[0];                      // One step per bit
        end
    endtask

    task automatic next_drive();
        @(posedge clock);
        #10;                                            // Drive point after the edge
    endtask

    task automatic record(input bit ok, input string what);
        assert (ok) else begin
            fail_cnt++;
            $display("FAIL %0d ns: %s", $time, what);
        end
        if (ok) begin
            pass_cnt++;
            $display("PASS %s", what);
        end
    endtask

    //////////////////////////////
    // Bus driver and monitors
    //////////////////////////////
    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        address  = addr;
        wr_data  = data;
        write_en = 1'b1;
        next_drive();                                   // Write lands at this edge
        write_en = 1'b0;
    endtask

    task automatic read_check(input reg_addr_t addr, input reg_data_t exp);
        reg_data_t want;
        want    = (addr == reg_addr_t'(`ADDR_FAULT_STAT)) ? reg_data_t'(sr_fault) : exp;
        address = addr;
        read_en = 1'b1;
        next_drive();
        read_en = 1'b0;
        record(rd_data === want, $sformatf("read 0x%02h got 0x%02h expected 0x%02h",
               addr, rd_data, want));
    endtask

    task automatic uart_check(input logic [1:0] ch, input reg_data_t exp);
        logic       prev;
        logic       edge_ok;
        logic [9:0] bits;
        int         first;
        @(negedge clock);
        do begin
            prev = sd_uart[ch];
            @(negedge clock);
        end while (since_reset % frame_clks != 0);
        edge_ok = (prev === 1'b1 && sd_uart[ch] === 1'b0);  // Stop to start edge
        first   = since_reset + frame_clks;                 // Skip one whole frame
        for (int b = 0; b < 10; b++) begin
            while (since_reset != first + b * `DRIVE_BAUD_DIV + `DRIVE_BAUD_DIV / 2)
                @(negedge clock);
            bits[b] = sd_uart[ch];                      // Bit middle
        end
        if (!edge_ok)
            record(1'b0, $sformatf("uart %0d shows no start edge at a frame boundary", ch));
        else
            record(bits[0] === 1'b0 && bits[8:1] === exp && bits[9] === 1'b1,
                   $sformatf("uart %0d frame 0x%03h expected byte 0x%02h", ch, bits, exp));
        next_drive();
    endtask

    task automatic pwm_check(input logic [1:0] ch, input int exp);
        int bounds;
        int high_cnt;
        bounds   = 0;
        high_cnt = 0;
        while (bounds < 2) begin
            @(negedge clock);
            if (since_reset % pwm_period == 1)
                bounds++;                               // Period start where nonzero rises
        end
        for (int i = 0; i < pwm_period; i++) begin
            if (servo_pwm[ch] === 1'b1)
                high_cnt++;
            @(negedge clock);
        end
        record(high_cnt == exp, $sformatf("pwm %0d high %0d of 256 expected %0d",
               ch, high_cnt, exp));
        next_drive();
    endtask

    task automatic led_check(input motor_mask_t mask, input logic f, input logic p,
                             input logic s, input logic d);
        sr_fault = mask;
        @(negedge clock);
        record(status_fault === f && status_pi === p && status_ps4 === s && status_debug === d,
               $sformatf("leds mask %h got %b%b%b%b expected %b%b%b%b", mask, status_fault,
               status_pi, status_ps4, status_debug, f, p, s, d));
        next_drive();
    endtask

    //////////////////////////////
    // Command file
    //////////////////////////////
    task automatic load_commands(output bit ok);
        int    fd;
        string line;
        fd = $fopen("verification/motor_input.txt", "r");
        ok = (fd != 0);
        if (!ok)
            $display("Cannot open verification/motor_input.txt, no commands run");
        else begin
            while ($fgets(line, fd) != 0) begin
                file_lines++;
                if (line.len() > 1 && line.getc(0) != "#")
                    cmd_lines.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    task automatic run_command(input string line);
        byte         op;
        logic [31:0] f1, f2, f3, f4, f5;
        void'($sscanf(line, "%c %h %h %h %h %h", op, f1, f2, f3, f4, f5));
        if (op != "L")
            draw_fault();                               // LED lines set the mask
        case (op)
            "W":     bus_write(reg_addr_t'(f1), reg_data_t'(f2));
            "R":     read_check(reg_addr_t'(f1), reg_data_t'(f2));
            "U":     uart_check(f1[1:0], reg_data_t'(f2));
            "P":     pwm_check(f1[1:0], int'(f2));
            "L":     led_check(motor_mask_t'(f1), f2[0], f3[0], f4[0], f5[0]);
            default: record(1'b0, $sformatf("unknown command line: %s", line));
        endcase
    endtask

    initial begin
        reset_n  = 1'b0;
        address  = '0;
        write_en = 1'b0;
        wr_data  = '0;
        read_en  = 1'b0;
        sr_fault = '0;
        load_commands(loaded);
        cycle_limit = file_lines * 4000 + 100;
        repeat (8) @(posedge clock);
        #10;
        reset_n = 1'b1;
        foreach (cmd_lines[i])
            run_command(cmd_lines[i]);
        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (loaded && pass_cnt > 0 && fail_cnt == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- verification/motor_input.txt
# W addr data, bus write | R addr data, read check (fault address expects the driven mask)
# U chan byte, UART | P chan count, PWM high cycles | L mask fault pi ps4 debug, LED check
R 00 00
R 08 00
L 0 0 0 0 1
W 00 c5
W 01 2a
W 02 7f
W 03 80
W 04 00
W 05 ff
W 06 80
W 07 01
W 08 16
W 09 ff
W 3f 5a
R 01 2a
R 05 ff
R 08 16
R 09 00
R 3f 00
U 0 c5
U 1 2a
U 2 7f
U 3 80
W 00 3c
U 0 3c
P 0 00
P 1 ff
P 2 80
P 3 01
L 5 1 1 1 1
W 08 19
L 0 1 1 1 1
W 08 01
L 8 0 1 1 0

//--- vlog.f
+incdir+common
common/motor_pkg.sv
rtl/motor_regs.sv
drive_uart/drive_uart_tx.sv
rtl/servo_pwm.sv
rtl/motor_subsystem.sv
verification/motor_subsystem_checker.sv
verification/motor_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module motor_subsystem_tb -f vlog.f -o motor_sim
./obj_dir/motor_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "TEST OK" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
